/* src/tile_settings.svh */
//##########################################################################
// Memory link settings
// Network and memory widths, the CLINT address window and the
// configuration register map of the tile
//##########################################################################
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Network side
`define NOC_CORD_WIDTH  5
`define LEN_WIDTH       4
`define LINK_FLIT_WIDTH 32

// Memory side
`define PADDR_WIDTH     32
`define DWORD_WIDTH     64

// CLINT window; every other address goes to DRAM
`define CLINT_BASE      32'h0200_0000
`define CLINT_SIZE      32'h0100_0000

// Configuration registers
`define CFG_ADDR_WIDTH  8
`define CFG_ADDR_FREEZE 8'h02

`endif

/* src/noc_pkg.sv */
//##########################################################################
// Wormhole network types
// Coordinates, one direction of a ready-and-valid link and the header
// flit that opens every packet
//##########################################################################
`include "tile_settings.svh"

package noc_pkg;

   typedef logic [`NOC_CORD_WIDTH-1:0] noc_cord_t;

   // Opcode field carried in a header
   typedef logic [1:0] noc_op_t;

   // Forward valid and data, reverse ready
   typedef struct packed
   {
      logic                        v;
      logic [`LINK_FLIT_WIDTH-1:0] data;
      logic                        ready_and_rev;
   } link_flit_s;

   // Destination sits in the low bits so routers see it first
   typedef struct packed
   {
      logic [`LINK_FLIT_WIDTH-2*`NOC_CORD_WIDTH-`LEN_WIDTH-3:0] pad;
      noc_op_t                                                 op;
      noc_cord_t                                               src_cord;
      logic [`LEN_WIDTH-1:0]                                   len;
      noc_cord_t                                               dst_cord;
   } noc_header_s;

endpackage

/* src/mem_pkg.sv */
//##########################################################################
// Memory interface types
// Memory opcodes, command and response payloads, and the states of
// the link sequencer
//##########################################################################
`include "tile_settings.svh"

package mem_pkg;

   typedef enum logic [1:0]
   {
      e_mem_rd = 2'b00,
      e_mem_wr = 2'b01
   } mem_op_e;

   // Write data rides along with the command
   typedef struct packed
   {
      mem_op_e                 op;
      logic [`PADDR_WIDTH-1:0] addr;
      logic [`DWORD_WIDTH-1:0] data;
   } mem_cmd_s;

   typedef struct packed
   {
      mem_op_e                 op;
      logic [`PADDR_WIDTH-1:0] addr;
      logic [`DWORD_WIDTH-1:0] data;
   } mem_resp_s;

   typedef enum logic [2:0]
   {
      e_idle,
      e_send_header,
      e_send_body,
      e_wait_header,
      e_recv_body,
      e_deliver
   } link_state_e;

   // Body flits behind a command header: address, plus two data flits on writes
   function automatic logic [`LEN_WIDTH-1:0] cmd_len(mem_op_e op);
      return (op == e_mem_wr) ? `LEN_WIDTH'(3) : `LEN_WIDTH'(1);
   endfunction

endpackage

/* src/flit_counter.sv */
//##########################################################################
// Flit counter
// Loads the body length of a packet and counts down the flits that
// are still to move
//##########################################################################
`include "tile_settings.svh"

module flit_counter
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  load_i,
   input  logic [`LEN_WIDTH-1:0] len_i,
   input  logic                  step_i,
   output logic [`LEN_WIDTH-1:0] count_o,
   output logic                  last_o
);

   logic [`LEN_WIDTH-1:0] count_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         count_r <= '0;
      else if (load_i)
         count_r <= len_i;
      else if (step_i && (count_r != '0))
         count_r <= count_r - 1'b1;
   end

   assign count_o = count_r;

   // Also high on a header-only packet
   assign last_o = (count_r <= `LEN_WIDTH'(1));

endmodule

/* src/link_fsm.sv */
//##########################################################################
// Memory link sequencer
// Holds the configuration freeze bit and steps one command at a time
// through accept, send, receive and deliver
//##########################################################################
`include "tile_settings.svh"

module link_fsm
(
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       cfg_w_v_i,
   input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`DWORD_WIDTH-1:0]    cfg_data_i,
   input  logic                       mem_cmd_v_i,
   output logic                       mem_cmd_yumi_o,
   output logic                       mem_resp_v_o,
   input  logic                       mem_resp_ready_i,
   input  logic                       link_ready_i,
   input  logic                       link_v_i,
   output logic                       link_v_o,
   output logic                       link_ready_o,
   input  mem_pkg::mem_op_e           cmd_op_i,
   input  logic [`LEN_WIDTH-1:0]      rx_len_i,
   input  logic                       last_i,
   output logic                       load_o,
   output logic [`LEN_WIDTH-1:0]      len_o,
   output logic                       step_o,
   output logic                       capture_cmd_o,
   output logic                       send_header_o,
   output logic                       capture_rx_o,
   output logic                       rx_header_o
);

   import mem_pkg::*;

   link_state_e state_r;
   link_state_e state_n;
   logic        freeze_r;
   logic        tx_fire;
   logic        rx_fire;

   // Tile comes out of reset frozen
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= 1'b1;
      else if (cfg_w_v_i && (cfg_addr_i == `CFG_ADDR_FREEZE))
         freeze_r <= cfg_data_i[0];
   end

   assign mem_cmd_yumi_o = (state_r == e_idle) && mem_cmd_v_i && !freeze_r;
   assign capture_cmd_o  = mem_cmd_yumi_o;

   assign link_v_o      = (state_r == e_send_header) || (state_r == e_send_body);
   assign link_ready_o  = (state_r == e_wait_header) || (state_r == e_recv_body);
   assign mem_resp_v_o  = (state_r == e_deliver);
   assign send_header_o = (state_r == e_send_header);
   assign rx_header_o   = (state_r == e_wait_header);

   assign tx_fire      = link_v_o && link_ready_i;
   assign rx_fire      = link_ready_o && link_v_i;
   assign capture_rx_o = rx_fire;

   // Counter holds the body length of whichever packet is in flight
   assign load_o = (send_header_o && tx_fire) || (rx_header_o && rx_fire);
   assign len_o  = send_header_o ? cmd_len(cmd_op_i) : rx_len_i;
   assign step_o = ((state_r == e_send_body) && tx_fire)
                || ((state_r == e_recv_body) && rx_fire);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_idle:
            if (mem_cmd_yumi_o)
               state_n = e_send_header;
         e_send_header:
            if (tx_fire)
               state_n = e_send_body;
         e_send_body:
            if (tx_fire && last_i)
               state_n = e_wait_header;
         e_wait_header:
            if (rx_fire)
               state_n = (rx_len_i == '0) ? e_deliver : e_recv_body;
         e_recv_body:
            if (rx_fire && last_i)
               state_n = e_deliver;
         e_deliver:
            if (mem_resp_ready_i)
               state_n = e_idle;
         default:
            state_n = e_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_idle;
      else
         state_r <= state_n;
   end

endmodule

/* src/cmd_packer.sv */
//##########################################################################
// Command packer
// Holds the accepted memory command, picks DRAM or CLINT from the
// address and serializes the command packet onto the link
//##########################################################################
`include "tile_settings.svh"

module cmd_packer
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        capture_i,
   input  mem_pkg::mem_cmd_s           mem_cmd_i,
   input  noc_pkg::noc_cord_t          my_cord_i,
   input  noc_pkg::noc_cord_t          dram_cord_i,
   input  noc_pkg::noc_cord_t          clint_cord_i,
   input  logic                        send_header_i,
   input  logic [`LEN_WIDTH-1:0]       count_i,
   output mem_pkg::mem_op_e            cmd_op_o,
   output logic [`PADDR_WIDTH-1:0]     cmd_addr_o,
   output logic [`LINK_FLIT_WIDTH-1:0] flit_o
);

   import mem_pkg::*;
   import noc_pkg::*;

   mem_op_e                 op_r;
   logic [`PADDR_WIDTH-1:0] addr_r;
   logic [`DWORD_WIDTH-1:0] data_r;
   logic                    in_clint;
   noc_header_s             header;
   logic [`LEN_WIDTH-1:0]   body_idx;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         op_r <= e_mem_rd;
      else if (capture_i)
         op_r <= mem_cmd_i.op;
   end

   always_ff @(posedge clk_i)
   begin
      if (capture_i)
      begin
         addr_r <= mem_cmd_i.addr;
         data_r <= mem_cmd_i.data;
      end
   end

   // Address map
   assign in_clint = (addr_r >= `CLINT_BASE) && (addr_r < (`CLINT_BASE + `CLINT_SIZE));

   always_comb
   begin
      header          = '0;
      header.dst_cord = in_clint ? clint_cord_i : dram_cord_i;
      header.len      = cmd_len(op_r);
      header.src_cord = my_cord_i;
      header.op       = noc_op_t'(op_r);
   end

   // 0 is the address flit, then data low and data high
   assign body_idx = cmd_len(op_r) - count_i;

   always_comb
   begin
      if (send_header_i)
         flit_o = header;
      else
      begin
         case (body_idx)
            `LEN_WIDTH'(1): flit_o = data_r[`LINK_FLIT_WIDTH-1:0];
            `LEN_WIDTH'(2): flit_o = data_r[`DWORD_WIDTH-1:`LINK_FLIT_WIDTH];
            default:        flit_o = `LINK_FLIT_WIDTH'(addr_r);
         endcase
      end
   end

   assign cmd_op_o   = op_r;
   assign cmd_addr_o = addr_r;

endmodule

/* src/resp_unpacker.sv */
//##########################################################################
// Response unpacker
// Decodes the response header and gathers the body flits into a
// memory response for the held command address
//##########################################################################
`include "tile_settings.svh"

module resp_unpacker
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        capture_i,
   input  logic                        header_i,
   input  logic [`LINK_FLIT_WIDTH-1:0] flit_i,
   input  logic [`PADDR_WIDTH-1:0]     cmd_addr_i,
   output logic [`LEN_WIDTH-1:0]       rx_len_o,
   output mem_pkg::mem_resp_s          mem_resp_o
);

   import mem_pkg::*;
   import noc_pkg::*;

   noc_header_s             header;
   mem_op_e                 op_r;
   logic [`DWORD_WIDTH-1:0] data_r;

   assign header   = flit_i;
   assign rx_len_o = header.len;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         op_r <= e_mem_rd;
      else if (capture_i && header_i)
         op_r <= mem_op_e'(header.op);
   end

   // Low word arrives first and ends up in the bottom half
   always_ff @(posedge clk_i)
   begin
      if (capture_i)
      begin
         if (header_i)
            data_r <= '0;
         else
            data_r <= {flit_i, data_r[`DWORD_WIDTH-1:`LINK_FLIT_WIDTH]};
      end
   end

   assign mem_resp_o = '{op: op_r, addr: cmd_addr_i, data: data_r};

endmodule

/* src/mem_link_top.sv */
//##########################################################################
// Memory link top
// Tile memory path between memory commands and the wormhole link,
// built from the sequencer, flit counter, packer and unpacker
//##########################################################################
`include "tile_settings.svh"

module mem_link_top
(
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       cfg_w_v_i,
   input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input  logic [`DWORD_WIDTH-1:0]    cfg_data_i,
   input  mem_pkg::mem_cmd_s          mem_cmd_i,
   input  logic                       mem_cmd_v_i,
   output logic                       mem_cmd_yumi_o,
   output mem_pkg::mem_resp_s         mem_resp_o,
   output logic                       mem_resp_v_o,
   input  logic                       mem_resp_ready_i,
   input  noc_pkg::link_flit_s        link_i,
   output noc_pkg::link_flit_s        link_o,
   input  noc_pkg::noc_cord_t         my_cord_i,
   input  noc_pkg::noc_cord_t         dram_cord_i,
   input  noc_pkg::noc_cord_t         clint_cord_i
);

   import mem_pkg::*;

   mem_op_e                     cmd_op;
   logic [`PADDR_WIDTH-1:0]     cmd_addr;
   logic [`LEN_WIDTH-1:0]       len;
   logic [`LEN_WIDTH-1:0]       count;
   logic [`LEN_WIDTH-1:0]       rx_len;
   logic                        load;
   logic                        step;
   logic                        last;
   logic                        capture_cmd;
   logic                        send_header;
   logic                        capture_rx;
   logic                        rx_header;
   logic                        link_v;
   logic                        link_ready;
   logic [`LINK_FLIT_WIDTH-1:0] tx_flit;

   assign link_o = '{v: link_v, data: tx_flit, ready_and_rev: link_ready};

   link_fsm fsm
   (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .cfg_w_v_i(cfg_w_v_i),
      .cfg_addr_i(cfg_addr_i),
      .cfg_data_i(cfg_data_i),
      .mem_cmd_v_i(mem_cmd_v_i),
      .mem_cmd_yumi_o(mem_cmd_yumi_o),
      .mem_resp_v_o(mem_resp_v_o),
      .mem_resp_ready_i(mem_resp_ready_i),
      .link_ready_i(link_i.ready_and_rev),
      .link_v_i(link_i.v),
      .link_v_o(link_v),
      .link_ready_o(link_ready),
      .cmd_op_i(cmd_op),
      .rx_len_i(rx_len),
      .last_i(last),
      .load_o(load),
      .len_o(len),
      .step_o(step),
      .capture_cmd_o(capture_cmd),
      .send_header_o(send_header),
      .capture_rx_o(capture_rx),
      .rx_header_o(rx_header)
   );

   flit_counter flit_cnt
   (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .load_i(load),
      .len_i(len),
      .step_i(step),
      .count_o(count),
      .last_o(last)
   );

   cmd_packer packer
   (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .capture_i(capture_cmd),
      .mem_cmd_i(mem_cmd_i),
      .my_cord_i(my_cord_i),
      .dram_cord_i(dram_cord_i),
      .clint_cord_i(clint_cord_i),
      .send_header_i(send_header),
      .count_i(count),
      .cmd_op_o(cmd_op),
      .cmd_addr_o(cmd_addr),
      .flit_o(tx_flit)
   );

   resp_unpacker unpacker
   (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .capture_i(capture_rx),
      .header_i(rx_header),
      .flit_i(link_i.data),
      .cmd_addr_i(cmd_addr),
      .rx_len_o(rx_len),
      .mem_resp_o(mem_resp_o)
   );

endmodule

/* verif/mem_link_assertions.sv */
//##########################################################################
// Memory link protocol checks
// Command, link and response handshake rules of the link sequencer
//##########################################################################
`include "tile_settings.svh"

module mem_link_assertions
(
   input logic                       clk_i,
   input logic                       reset_i,
   input logic                       cfg_w_v_i,
   input logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
   input logic                       cfg_bit_i,
   input logic                       mem_cmd_v_i,
   input logic                       mem_cmd_yumi_i,
   input logic                       link_v_i,
   input logic                       link_ready_i,
   input logic                       mem_resp_v_i,
   input logic                       mem_resp_ready_i
);

   timeunit 1ns;
   timeprecision 100ps;

   int   fail_count = 0;
   logic frozen;

   // Freeze state as seen from the configuration writes
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         frozen <= 1'b1;
      else if (cfg_w_v_i && (cfg_addr_i == `CFG_ADDR_FREEZE))
         frozen <= cfg_bit_i;
   end

   // Command only taken while offered and unfrozen
   yumi_rule: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_cmd_yumi_i |-> (mem_cmd_v_i && !frozen))
   else
   begin
      fail_count++;
      $error("yumi raised without a valid command or while frozen");
   end

   // Outgoing flit waits for the far end
   link_hold_rule: assert property (@(posedge clk_i) disable iff (reset_i)
      (link_v_i && !link_ready_i) |=> link_v_i)
   else
   begin
      fail_count++;
      $error("link valid dropped before the flit was taken");
   end

   resp_hold_rule: assert property (@(posedge clk_i) disable iff (reset_i)
      (mem_resp_v_i && !mem_resp_ready_i) |=> mem_resp_v_i)
   else
   begin
      fail_count++;
      $error("response valid dropped before the response was taken");
   end

endmodule

bind link_fsm mem_link_assertions link_checks
(
   .clk_i(clk_i),
   .reset_i(reset_i),
   .cfg_w_v_i(cfg_w_v_i),
   .cfg_addr_i(cfg_addr_i),
   .cfg_bit_i(cfg_data_i[0]),
   .mem_cmd_v_i(mem_cmd_v_i),
   .mem_cmd_yumi_i(mem_cmd_yumi_o),
   .link_v_i(link_v_o),
   .link_ready_i(link_ready_i),
   .mem_resp_v_i(mem_resp_v_o),
   .mem_resp_ready_i(mem_resp_ready_i)
);

/* verif/tb_mem_link.sv */
//##########################################################################
// Memory link testbench
// Random memory commands through the tile memory path, a remote memory
// endpoint on the link and a reference memory for every response
//##########################################################################
`include "tile_settings.svh"

module tb_mem_link;

   timeunit 1ns;
   timeprecision 100ps;

   import mem_pkg::*;
   import noc_pkg::*;

   // 1 + 26 + 12 + 40 + 1 commands over the five tests
   localparam int NUM_OPS     = 80;
   localparam int OP_CYCLES   = 150;
   localparam int CYCLE_LIMIT = NUM_OPS * OP_CYCLES + 200;

   logic                       clk_i;
   logic                       reset_i;
   logic                       cfg_w_v_i;
   logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i;
   logic [`DWORD_WIDTH-1:0]    cfg_data_i;
   mem_cmd_s                   mem_cmd_i;
   logic                       mem_cmd_v_i;
   logic                       mem_cmd_yumi_o;
   mem_resp_s                  mem_resp_o;
   logic                       mem_resp_v_o;
   logic                       mem_resp_ready_i;
   link_flit_s                 link_i;
   link_flit_s                 link_o;
   noc_cord_t                  my_cord_i;
   noc_cord_t                  dram_cord_i;
   noc_cord_t                  clint_cord_i;

   // Scoreboard and remote endpoint state
   mem_cmd_s    cur_cmd;
   logic [63:0] exp_data;
   logic        cmd_pending  = 1'b0;
   logic        awaiting_pkt = 1'b0;
   logic        rx_taken     = 1'b0;
   int          cmds_offered = 0;
   int          accepted_count = 0;
   int          resp_count   = 0;
   int          resp_delay   = 0;
   int          drop_pct     = 25;
   int          error_count  = 0;
   int          check_count  = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          cycle_count  = 0;
   logic [31:0] pkt_q [$];
   logic [31:0] resp_q [$];
   logic [63:0] ref_mem [logic [31:0]];
   logic [63:0] remote_mem [logic [31:0]];

   mem_link_top dut0
   (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .cfg_w_v_i(cfg_w_v_i),
      .cfg_addr_i(cfg_addr_i),
      .cfg_data_i(cfg_data_i),
      .mem_cmd_i(mem_cmd_i),
      .mem_cmd_v_i(mem_cmd_v_i),
      .mem_cmd_yumi_o(mem_cmd_yumi_o),
      .mem_resp_o(mem_resp_o),
      .mem_resp_v_o(mem_resp_v_o),
      .mem_resp_ready_i(mem_resp_ready_i),
      .link_i(link_i),
      .link_o(link_o),
      .my_cord_i(my_cord_i),
      .dram_cord_i(dram_cord_i),
      .clint_cord_i(clint_cord_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic report_failure(string msg);
      error_count++;
      $display("Failure at %0d ns: %s", $time, msg);
   endtask

   function automatic logic in_clint_window(logic [31:0] addr);
      return (addr >= `CLINT_BASE) && (addr < (`CLINT_BASE + `CLINT_SIZE));
   endfunction

   // Flits behind the header of a command packet
   function automatic int body_len(mem_op_e op);
      return (op == e_mem_wr) ? 3 : 1;
   endfunction

   function automatic logic ready_draw();
      return ($urandom % 100) >= drop_pct;
   endfunction

   function automatic logic [31:0] rand_addr(logic clint);
      logic [31:0] a;
      if (clint)
         a = `CLINT_BASE + ($urandom % `CLINT_SIZE);
      else
      begin
         a = $urandom;
         if (in_clint_window(a))
            a = a ^ 32'h1000_0000;
      end
      return {a[31:3], 3'b000};
   endfunction

   function automatic logic [63:0] rand_dword();
      return {$urandom, $urandom};
   endfunction

   task automatic note_accept();
      cur_cmd = mem_cmd_i;
      if (cmd_pending)
         report_failure("command accepted while another one is outstanding");
      cmd_pending  = 1'b1;
      awaiting_pkt = 1'b1;
      accepted_count++;
      if (cur_cmd.op == e_mem_wr)
      begin
         ref_mem[cur_cmd.addr] = cur_cmd.data;
         exp_data = '0;
      end
      else
         exp_data = ref_mem.exists(cur_cmd.addr) ? ref_mem[cur_cmd.addr] : '0;
   endtask

   // Remote endpoint executes the packet and queues its answer
   task automatic answer_packet();
      noc_header_s hdr;
      noc_header_s resp_hdr;
      noc_cord_t   exp_dst;
      logic [63:0] wdata;
      logic [63:0] rdata;
      hdr     = pkt_q[0];
      exp_dst = in_clint_window(cur_cmd.addr) ? clint_cord_i : dram_cord_i;
      check_value("header dst_cord", hdr.dst_cord, exp_dst);
      check_value("header src_cord", hdr.src_cord, my_cord_i);
      check_value("header len", hdr.len, body_len(cur_cmd.op));
      check_value("header op", hdr.op, cur_cmd.op);
      check_value("address flit", pkt_q[1], cur_cmd.addr);
      resp_hdr          = '0;
      resp_hdr.dst_cord = hdr.src_cord;
      resp_hdr.src_cord = hdr.dst_cord;
      resp_hdr.op       = hdr.op;
      if (cur_cmd.op == e_mem_wr)
      begin
         wdata = {pkt_q[3], pkt_q[2]};
         check_value("write data flits", wdata, cur_cmd.data);
         remote_mem[pkt_q[1]] = wdata;
         resp_hdr.len = 4'd0;
         resp_q.push_back(resp_hdr);
      end
      else
      begin
         rdata = remote_mem.exists(pkt_q[1]) ? remote_mem[pkt_q[1]] : '0;
         resp_hdr.len = 4'd2;
         resp_q.push_back(resp_hdr);
         resp_q.push_back(rdata[31:0]);
         resp_q.push_back(rdata[63:32]);
      end
      pkt_q.delete();
      awaiting_pkt = 1'b0;
      resp_delay   = $urandom % 5;
   endtask

   task automatic take_cmd_flit(logic [31:0] flit);
      if (!awaiting_pkt)
      begin
         report_failure("flit sent on the link with no command packet expected");
         return;
      end
      pkt_q.push_back(flit);
      if (pkt_q.size() == body_len(cur_cmd.op) + 1)
         answer_packet();
   endtask

   task automatic take_response();
      if (!cmd_pending)
      begin
         report_failure("response delivered with no command outstanding");
         return;
      end
      if (awaiting_pkt)
         report_failure("response delivered before the command packet was complete");
      check_value("mem_resp_o.op", mem_resp_o.op, cur_cmd.op);
      check_value("mem_resp_o.addr", mem_resp_o.addr, cur_cmd.addr);
      if (cur_cmd.op == e_mem_rd)
         check_value("mem_resp_o.data", mem_resp_o.data, exp_data);
      cmd_pending = 1'b0;
      resp_count++;
   endtask

   // Handshakes are sampled mid-cycle and complete on the next rising edge
   initial
   begin
      forever
      begin
         @(negedge clk_i);
         if (!reset_i)
         begin
            if (mem_cmd_yumi_o)
               note_accept();
            if (link_o.v && link_i.ready_and_rev)
               take_cmd_flit(link_o.data);
            if (link_i.v && link_o.ready_and_rev && (resp_q.size() > 0))
            begin
               void'(resp_q.pop_front());
               rx_taken = 1'b1;
            end
            if (mem_resp_v_o && mem_resp_ready_i)
               take_response();
         end
      end
   end

   task automatic drive_backpressure();
      link_i.ready_and_rev = ready_draw();
      mem_resp_ready_i     = ready_draw();
      if (link_i.v && !rx_taken)
         return;
      rx_taken = 1'b0;
      if ((resp_delay == 0) && (resp_q.size() > 0) && ready_draw())
      begin
         link_i.v    = 1'b1;
         link_i.data = resp_q[0];
      end
      else
      begin
         link_i.v    = 1'b0;
         link_i.data = $urandom;
         if (resp_delay > 0)
            resp_delay--;
      end
   endtask

   initial
   begin
      link_i           = '0;
      mem_resp_ready_i = 1'b0;
      forever
      begin
         @(posedge clk_i);
         #2;
         drive_backpressure();
      end
   end

   initial
   begin
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk_i);
         cycle_count++;
      end
      $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic offer_cmd(mem_op_e op, logic [31:0] addr, logic [63:0] data);
      mem_cmd_i   = '{op: op, addr: addr, data: data};
      mem_cmd_v_i = 1'b1;
      cmds_offered++;
   endtask

   task automatic complete_cmd();
      while (accepted_count < cmds_offered)
      begin
         @(posedge clk_i);
         #2;
      end
      mem_cmd_v_i = 1'b0;
      while (resp_count < cmds_offered)
      begin
         @(posedge clk_i);
         #2;
      end
   endtask

   task automatic run_cmd(mem_op_e op, logic [31:0] addr, logic [63:0] data);
      repeat ($urandom % 3)
      begin
         @(posedge clk_i);
         #2;
      end
      offer_cmd(op, addr, data);
      complete_cmd();
   endtask

   task automatic write_freeze(logic val);
      cfg_w_v_i  = 1'b1;
      cfg_addr_i = `CFG_ADDR_FREEZE;
      cfg_data_i = {63'b0, val};
      @(posedge clk_i);
      #2;
      cfg_w_v_i  = 1'b0;
      cfg_data_i = '0;
   endtask

   task automatic expect_frozen(int cycles);
      repeat (cycles)
      begin
         @(negedge clk_i);
         check_value("mem_cmd_yumi_o", mem_cmd_yumi_o, 1'b0);
         check_value("link_o.v", link_o.v, 1'b0);
      end
      @(posedge clk_i);
      #2;
   endtask

   // Pending command must be taken in the first unfrozen cycle
   task automatic expect_accept();
      @(negedge clk_i);
      check_value("mem_cmd_yumi_o", mem_cmd_yumi_o, 1'b1);
      @(posedge clk_i);
      #2;
   endtask

   task automatic finish_test(string name, int errs_before);
      tests_run++;
      if (error_count == errs_before)
         $display("Test %s passed", name);
      else
      begin
         tests_failed++;
         $display("Test %s failed with %0d errors", name, error_count - errs_before);
      end
   endtask

   task automatic test_freeze_after_reset();
      int errs;
      errs = error_count;
      offer_cmd(e_mem_wr, rand_addr(1'b0), rand_dword());
      expect_frozen(10);
      write_freeze(1'b0);
      expect_accept();
      complete_cmd();
      finish_test("freeze_after_reset", errs);
   endtask

   task automatic test_write_read();
      logic [31:0] pool [8];
      int          errs;
      errs = error_count;
      foreach (pool[i])
         pool[i] = rand_addr(i % 2 == 0);
      repeat (16)
         run_cmd(e_mem_wr, pool[$urandom % 8], rand_dword());
      foreach (pool[i])
         run_cmd(e_mem_rd, pool[i], rand_dword());
      // Never written
      run_cmd(e_mem_rd, rand_addr(1'b0), rand_dword());
      run_cmd(e_mem_rd, rand_addr(1'b1), rand_dword());
      finish_test("write_read", errs);
   endtask

   task automatic test_address_map();
      logic [31:0] edges [6];
      int          errs;
      errs  = error_count;
      edges = '{`CLINT_BASE - 32'd8, `CLINT_BASE, `CLINT_BASE + `CLINT_SIZE - 32'd8,
                `CLINT_BASE + `CLINT_SIZE, 32'h0000_0000, 32'hFFFF_FFF8};
      foreach (edges[i])
      begin
         run_cmd(e_mem_wr, edges[i], rand_dword());
         run_cmd(e_mem_rd, edges[i], rand_dword());
      end
      finish_test("address_map", errs);
   endtask

   task automatic test_backpressure();
      logic [31:0] pool [6];
      int          errs;
      errs     = error_count;
      drop_pct = 50;
      foreach (pool[i])
         pool[i] = rand_addr(i < 3);
      repeat (40)
      begin
         if ($urandom % 2)
            run_cmd(e_mem_wr, pool[$urandom % 6], rand_dword());
         else
            run_cmd(e_mem_rd, pool[$urandom % 6], rand_dword());
      end
      drop_pct = 25;
      finish_test("backpressure", errs);
   endtask

   task automatic test_refreeze();
      int errs;
      errs = error_count;
      write_freeze(1'b1);
      offer_cmd(e_mem_rd, rand_addr(1'b1), rand_dword());
      expect_frozen(8);
      write_freeze(1'b0);
      expect_accept();
      complete_cmd();
      finish_test("refreeze", errs);
   endtask

   initial
   begin
      void'($urandom(82131));
      reset_i      = 1'b1;
      cfg_w_v_i    = 1'b0;
      cfg_addr_i   = '0;
      cfg_data_i   = '0;
      mem_cmd_i    = '0;
      mem_cmd_v_i  = 1'b0;
      my_cord_i    = 5'd3;
      dram_cord_i  = 5'd12;
      clint_cord_i = 5'd20;
      repeat (4) @(posedge clk_i);
      #2;
      reset_i = 1'b0;

      test_freeze_after_reset();
      test_write_read();
      test_address_map();
      test_backpressure();
      test_refreeze();

      if (dut0.fsm.link_checks.fail_count != 0)
         report_failure("protocol assertions on link_fsm failed");
      check_value("responses", resp_count, cmds_offered);
      $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* all.f */
+incdir+src
src/noc_pkg.sv
src/mem_pkg.sv
src/flit_counter.sv
src/link_fsm.sv
src/cmd_packer.sv
src/resp_unpacker.sv
src/mem_link_top.sv
verif/mem_link_assertions.sv
verif/tb_mem_link.sv

/* Makefile */
# Verilator build and run of the memory link testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_link
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator, run it and look for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS RUN_ARGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
